// ==== all.f ====
hw/lfsr_pkg.sv
hw/lfsr_step_ctrl.sv
hw/lfsr_core.sv
hw/lfsr_pin_top.sv
test/lfsr_pin_top_chk.sv
test/tb_lfsr_pin_top.sv

// ==== Bender.yml ====
# length-programmable fibonacci lfsr tile

package:
  name: lfsr_pin_top

sources:
  # rtl, package first
  - files:
      - hw/lfsr_pkg.sv
      - hw/lfsr_step_ctrl.sv
      - hw/lfsr_core.sv
      - hw/lfsr_pin_top.sv

  # testbench and bound checks
  - target: test
    files:
      - test/lfsr_pin_top_chk.sv
      - test/tb_lfsr_pin_top.sv

// ==== test/tb_lfsr_pin_top.sv ====
// lfsr pin-level testbench
// free run, period, single step, invalid length and random mix against a
// cycle model built from the step and shift rules

`timescale 1ns/1ps
`default_nettype none

module tb_lfsr_pin_top;

    import lfsr_pkg::*;

    localparam lfsr_t seed_value   = 32'h0000_0001;
    localparam int    clk_period   = 4;
    localparam int    reset_cycles = 4;
    localparam int    hold_presses = 12;
    localparam int    rand_iters   = 300;

    // longest runs, doubled for the wait before the first shown value
    localparam int period_cycles = 2 * ((1 << 3) + (1 << 4) + (1 << 5) + (1 << 7)
                                      + (1 << 5) + (1 << 8) + (1 << 12));
    localparam int test_cycles   = period_cycles + hold_presses * 16 + 3 * 40
                                 + rand_iters * 4 + 400 + 20 * (reset_cycles + 24);
    localparam int margin_cycles = 1000;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    int value_errors = 0;
    int other_errors = 0;

    // model state, mirrors step control, core and pin register
    logic       m_step_q;
    logic       m_adv;
    lfsr_t      m_value;
    logic       m_valid;
    logic [7:0] m_uo;
    logic [7:0] m_uio;
    logic       m_ready = 1'b0;

    lfsr_pin_top #(
        .SEED (seed_value)
    ) u_lfsr_pin_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .ena     (ena),
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // reference model

    // one fibonacci step, or the all-zero invalid state when no mask exists
    function automatic mask_t next_state(input lfsr_t cur, input len_t len,
                                         input tap_mode_e mode);
        mask_t entry;
        mask_t result;
        logic  fb;
        int    i;
        entry = (mode == taps_four) ? tap_table_four[len] : tap_table_two[len];
        fb = 1'b0;
        for (i = 0; i < lfsr_width; i++) begin
            if (entry.value[i]) begin
                fb = fb ^ cur[i];
            end
        end
        if (entry.valid) begin
            result.valid = 1'b1;
            result.value = {cur[lfsr_width-2:0], fb};
        end else begin
            result = '0;
        end
        return result;
    endfunction

    always @(posedge clk) begin : track_model
        lfsr_ctrl_t seen;
        mask_t      nxt;
        seen = lfsr_ctrl_t'(ui_in);
        if (!rst_n) begin
            m_step_q = 1'b0;
            m_adv    = 1'b0;
            m_value  = seed_value;
            m_valid  = 1'b1;
            m_uo     = '0;
            m_uio    = '0;
            m_ready  = 1'b1;
        end else begin
            if (m_adv) begin
                m_uo    = m_value[7:0];               // pins get the old state
                m_uio   = {m_valid, m_value[14:8]};
                nxt     = next_state(m_value, seen.length, seen.tap_mode);
                m_value = nxt.value;
                m_valid = nxt.valid;
            end
            m_adv    = !seen.hold ? 1'b1 : (seen.step & ~m_step_q);
            m_step_q = seen.step;
        end
    end

    // outputs settle long before the falling edge
    always @(negedge clk) begin : compare_pins
        if (m_ready) begin
            assert (uo_out === m_uo) else begin
                value_errors++;
                $display("FAIL uo_out got %h expected %h at %0t", uo_out, m_uo, $time);
            end
            assert (uio_out === m_uio) else begin
                value_errors++;
                $display("FAIL uio_out got %h expected %h at %0t", uio_out, m_uio, $time);
            end
            assert (uio_oe === 8'hff) else begin
                value_errors++;
                $display("FAIL uio_oe got %h expected ff at %0t", uio_oe, $time);
            end
        end
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic drive_ctrl(input logic hold, input logic step, input tap_mode_e mode,
                              input len_t len);
        lfsr_ctrl_t c;
        c.hold     = hold;
        c.step     = step;
        c.tap_mode = mode;
        c.length   = len;
        ui_in      = c;
    endtask

    task automatic apply_reset(input logic hold, input tap_mode_e mode, input len_t len);
        drive_ctrl(hold, 1'b0, mode, len);
        rst_n = 1'b0;
        wait_cycles(reset_cycles);
        rst_n = 1'b1;
    endtask

    function automatic logic [14:0] shown_value();
        return {uio_out[6:0], uo_out};
    endfunction

    task automatic check_pins(input logic [7:0] exp_uo, input logic [7:0] exp_uio);
        assert (uo_out === exp_uo) else begin
            value_errors++;
            $display("FAIL uo_out got %h expected %h at %0t", uo_out, exp_uo, $time);
        end
        assert (uio_out === exp_uio) else begin
            value_errors++;
            $display("FAIL uio_out got %h expected %h at %0t", uio_out, exp_uio, $time);
        end
    endtask

    // ends on the falling edge where the seed first shows
    task automatic wait_first_valid();
        int n;
        n = 0;
        while (uio_out[7] !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (uio_out[7] === 1'b1) else begin
            other_errors++;
            $display("valid never rose on the pins after reset at %0t", $time);
        end
    endtask

    task automatic measure_period(input tap_mode_e mode, input int len);
        logic [14:0] len_mask;
        logic [14:0] first;
        int          count;
        logic        found;
        len_mask = (15'd1 << len) - 15'd1;
        apply_reset(1'b0, mode, len_t'(len));
        wait_first_valid();
        first = shown_value() & len_mask;
        count = 0;
        found = 1'b0;
        while (!found && count < (1 << len) + 8) begin
            @(negedge clk);
            count++;
            if ((shown_value() & len_mask) == first) begin
                found = 1'b1;
            end
        end
        assert (found && count == (1 << len) - 1) else begin
            value_errors++;
            $display("FAIL period mode %0d len %0d got %h expected %h",
                     mode, len, count, (1 << len) - 1);
        end
        wait_cycles(1);
    endtask

    function automatic len_t pick_length(input tap_mode_e mode);
        len_t  len;
        mask_t entry;
        do begin
            len   = len_t'($urandom % 32);
            entry = (mode == taps_four) ? tap_table_four[len] : tap_table_two[len];
        end while (!entry.valid);
        return len;
    endfunction

    //////////////////////////////////////////////////
    // tests

    task automatic run_free_run();
        apply_reset(1'b0, taps_two, 5'd4);
        check_pins(8'h00, 8'h00);              // still zero right after reset
        wait_first_valid();
        check_pins(seed_value[7:0], {1'b1, seed_value[14:8]});
        wait_cycles(40);
        drive_ctrl(1'b0, 1'b0, taps_four, 5'd8);
        wait_cycles(300);
    endtask

    task automatic run_periods();
        measure_period(taps_two, 3);
        measure_period(taps_two, 4);
        measure_period(taps_two, 5);
        measure_period(taps_two, 7);
        measure_period(taps_four, 5);
        measure_period(taps_four, 8);
        measure_period(taps_four, 12);
    endtask

    task automatic run_single_step();
        logic [15:0] prev;
        int          changes;
        int          high_len;
        int          gap;
        apply_reset(1'b1, taps_two, 5'd4);
        wait_cycles(10);
        check_pins(8'h00, 8'h00);              // no press, nothing moves
        for (int p = 0; p < hold_presses; p++) begin
            changes  = 0;
            prev     = {uio_out[7], shown_value()} ;
            high_len = 1 + $urandom % 8;
            gap      = 2 + $urandom % 5;
            drive_ctrl(1'b1, 1'b1, taps_two, 5'd4);
            repeat (high_len + gap) begin
                if (high_len == 0) begin
                    drive_ctrl(1'b1, 1'b0, taps_two, 5'd4);
                end
                wait_cycles(1);
                high_len--;
                if ({uio_out[7], shown_value()} != prev) begin
                    changes++;
                    prev = {uio_out[7], shown_value()};
                end
            end
            drive_ctrl(1'b1, 1'b0, taps_two, 5'd4);
            assert (changes == 1) else begin
                other_errors++;
                $display("step press %0d moved the outputs %0d times instead of once",
                         p, changes);
            end
        end
    endtask

    task automatic run_invalid_lengths();
        len_t bad [3];
        bad = '{5'd8, 5'd12, 5'd0};
        foreach (bad[i]) begin
            apply_reset(1'b0, taps_two, 5'd4);
            wait_cycles(12);
            drive_ctrl(1'b0, 1'b0, taps_two, bad[i]);
            wait_cycles(4);
            check_pins(8'h00, 8'h00);          // valid low, value zero
            drive_ctrl(1'b0, 1'b0, taps_two, 5'd4);
            wait_cycles(12);
            check_pins(8'h00, 8'h80);          // valid back, value stuck at zero
        end
        apply_reset(1'b0, taps_two, 5'd4);     // seed comes back
        wait_first_valid();
        check_pins(seed_value[7:0], {1'b1, seed_value[14:8]});
        wait_cycles(1);
    endtask

    task automatic run_random_mix();
        tap_mode_e mode;
        apply_reset(1'b0, taps_two, 5'd4);
        for (int n = 0; n < rand_iters; n++) begin
            mode = tap_mode_e'($urandom % 2);
            drive_ctrl(1'($urandom % 2), 1'($urandom % 2), mode, pick_length(mode));
            wait_cycles(1 + $urandom % 4);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin : main_sequence
        void'($urandom(7045));
        rst_n  = 1'b0;
        ena    = 1'b1;
        uio_in = 8'h00;
        ui_in  = 8'h00;
        run_free_run();
        run_periods();
        run_single_step();
        run_invalid_lengths();
        run_random_mix();
        wait_cycles(2);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #((test_cycles + margin_cycles) * clk_period);
        $display("run did not finish within %0d cycles", test_cycles + margin_cycles);
        $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/lfsr_pin_top_chk.sv ====
// lfsr pin checks
// concurrent assertions on the pin-level top, attached by bind

`timescale 1ns/1ps
`default_nettype none

module lfsr_pin_top_chk (
    input logic       clk,
    input logic       rst_n,
    input logic [7:0] ui_in,
    input logic [7:0] uo_out,
    input logic [7:0] uio_out,
    input logic [7:0] uio_oe
);

    import lfsr_pkg::*;

    lfsr_ctrl_t ctrl;

    assign ctrl = lfsr_ctrl_t'(ui_in);

    //////////////////////////////////////////////////
    // pin properties

    a_oe_all_ones : assert property (@(posedge clk) uio_oe == 8'hff)
        else $error("uio_oe not driven all ones");

    a_zero_after_reset : assert property (@(posedge clk)
        !rst_n |=> (uo_out == 8'h00 && uio_out == 8'h00))
        else $error("outputs not zero in the cycle after reset");

    // invalid state always shows as zero value bits
    a_invalid_is_zero : assert property (@(posedge clk) disable iff (!rst_n)
        !uio_out[7] |-> (uo_out == 8'h00 && uio_out[6:0] == 7'h00))
        else $error("value bits nonzero while valid is low");

    // a rise two edges back is the only thing that moves the pins in hold mode
    a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3)
         && $past(ctrl.hold, 2)
         && !($past(ctrl.step, 2) && !$past(ctrl.step, 3)))
        |-> $stable({uo_out, uio_out}))
        else $error("outputs changed in hold mode without a step press");

endmodule

bind lfsr_pin_top lfsr_pin_top_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
);

`default_nettype wire

// ==== hw/lfsr_pin_top.sv ====
// lfsr pin-level top
// decodes the dedicated input pins, runs step control and the register core,
// and drives a registered view of the low value bits and valid onto the pins

`timescale 1ns/1ps
`default_nettype none

module lfsr_pin_top #(
    parameter lfsr_pkg::lfsr_t SEED = 1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ena,       // always high on the tile
    input  logic [7:0] ui_in,
    input  logic [7:0] uio_in,    // bidir pins are outputs only
    output logic [7:0] uo_out,
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe
);

    import lfsr_pkg::*;

    lfsr_ctrl_t                 ctrl;
    logic                       advance;
    lfsr_t                      core_value;
    logic                       core_valid;
    logic [out_value_width-1:0] shown;       // bits that reach the pins

    //////////////////////////////////////////////////
    // input decode

    assign ctrl = lfsr_ctrl_t'(ui_in);

    lfsr_step_ctrl u_step (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold    (ctrl.hold),
        .step    (ctrl.step),
        .advance (advance)
    );

    lfsr_core #(
        .SEED (SEED)
    ) u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .tap_mode (ctrl.tap_mode),
        .length   (ctrl.length),
        .value    (core_value),
        .valid    (core_valid)
    );

    assign shown = core_value[out_value_width-1:0];

    //////////////////////////////////////////////////
    // output pins

    // loads on the same advance as the core, so pins show the state before it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uo_out  <= '0;
            uio_out <= '0;
        end else if (advance) begin
            uo_out  <= shown[7:0];
            uio_out <= {core_valid, shown[out_value_width-1:8]};  // valid on bit 7
        end
    end

    assign uio_oe = '1;  // all bidir pins driven

endmodule

`default_nettype wire

// ==== hw/lfsr_core.sv ====
// lfsr register core
// picks the feedback mask for the current length and tap mode and holds
// the fibonacci shift register, forced to zero on a length with no mask

`timescale 1ns/1ps
`default_nettype none

module lfsr_core #(
    parameter lfsr_pkg::lfsr_t SEED = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  lfsr_pkg::tap_mode_e tap_mode,
    input  lfsr_pkg::len_t      length,
    output lfsr_pkg::lfsr_t     value,
    output logic                valid
);

    import lfsr_pkg::*;

    mask_t mask_sel;
    logic  feedback;

    //////////////////////////////////////////////////
    // mask lookup

    always_comb begin
        if (tap_mode == taps_four) begin
            mask_sel = tap_table_four[length];
        end else begin
            mask_sel = tap_table_two[length];
        end
    end

    // parity of the tapped bits
    assign feedback = ^(value & mask_sel.value);

    //////////////////////////////////////////////////
    // shift register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= SEED;
            valid <= 1'b1;
        end else if (advance) begin
            if (mask_sel.valid) begin
                value <= {value[lfsr_width-2:0], feedback};
                valid <= 1'b1;
            end else begin
                // no table entry, lock up at zero until reset
                value <= '0;
                valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/lfsr_step_ctrl.sv ====
// lfsr step control
// turns the hold level and step strobe into a registered advance enable,
// continuous when free running and one cycle per press in hold mode

`timescale 1ns/1ps
`default_nettype none

module lfsr_step_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic hold,
    input  logic step,
    output logic advance
);

    logic step_q;      // step as sampled at the previous edge
    logic step_rise;

    // new press only when step was low at the edge before
    assign step_rise = step & ~step_q;

    //////////////////////////////////////////////////
    // edge history

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q <= 1'b0;
        end else begin
            step_q <= step;
        end
    end

    //////////////////////////////////////////////////
    // advance enable

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            advance <= 1'b0;
        end else if (!hold) begin
            advance <= 1'b1;       // free run
        end else begin
            advance <= step_rise;  // single step, one pulse however long step stays high
        end
    end

endmodule

`default_nettype wire

// ==== hw/lfsr_pkg.sv ====
// lfsr package
// widths, control and mask types, and the two- and four-tap feedback tables
// for the length-programmable fibonacci lfsr

`default_nettype none

package lfsr_pkg;

    //////////////////////////////////////////////////
    // widths

    localparam int lfsr_width      = 32;
    localparam int len_width       = $clog2(lfsr_width);  // 5 bits selects 0..31
    localparam int out_value_width = 15;                  // register bits on pins

    //////////////////////////////////////////////////
    // types

    typedef logic [len_width-1:0]  len_t;
    typedef logic [lfsr_width-1:0] lfsr_t;

    typedef enum logic {
        taps_two  = 1'b0,
        taps_four = 1'b1
    } tap_mode_e;

    // feedback mask plus a flag saying the length has an entry
    typedef struct packed {
        logic  valid;
        lfsr_t value;
    } mask_t;

    // field order follows ui_in, msb first
    typedef struct packed {
        logic      hold;
        logic      step;
        tap_mode_e tap_mode;
        len_t      length;
    } lfsr_ctrl_t;

    localparam mask_t mask_none = '{valid: 1'b0, value: '0};

    //////////////////////////////////////////////////
    // two-tap masks, bit n-1 always set for length n

    localparam mask_t tap_table_two [32] = '{
        mask_none,                                 // 0
        mask_none,                                 // 1
        '{valid: 1'b1, value: 32'h0000_0003},      // 2
        '{valid: 1'b1, value: 32'h0000_0006},      // 3
        '{valid: 1'b1, value: 32'h0000_000c},      // 4
        '{valid: 1'b1, value: 32'h0000_0014},      // 5
        '{valid: 1'b1, value: 32'h0000_0030},      // 6
        '{valid: 1'b1, value: 32'h0000_0060},      // 7
        mask_none,                                 // 8 needs four taps
        '{valid: 1'b1, value: 32'h0000_0110},      // 9
        '{valid: 1'b1, value: 32'h0000_0240},      // 10
        '{valid: 1'b1, value: 32'h0000_0500},      // 11
        mask_none,                                 // 12
        mask_none,                                 // 13
        mask_none,                                 // 14
        '{valid: 1'b1, value: 32'h0000_6000},      // 15
        mask_none,                                 // 16
        '{valid: 1'b1, value: 32'h0001_2000},      // 17
        '{valid: 1'b1, value: 32'h0002_0400},      // 18
        mask_none,                                 // 19
        '{valid: 1'b1, value: 32'h0009_0000},      // 20
        '{valid: 1'b1, value: 32'h0014_0000},      // 21
        '{valid: 1'b1, value: 32'h0030_0000},      // 22
        '{valid: 1'b1, value: 32'h0042_0000},      // 23
        mask_none,                                 // 24
        '{valid: 1'b1, value: 32'h0120_0000},      // 25
        mask_none,                                 // 26
        mask_none,                                 // 27
        '{valid: 1'b1, value: 32'h0900_0000},      // 28
        '{valid: 1'b1, value: 32'h1400_0000},      // 29
        mask_none,                                 // 30
        '{valid: 1'b1, value: 32'h4800_0000}       // 31
    };

    //////////////////////////////////////////////////
    // four-tap masks, nothing below length 5

    localparam mask_t tap_table_four [32] = '{
        mask_none,                                 // 0
        mask_none,                                 // 1
        mask_none,                                 // 2
        mask_none,                                 // 3
        mask_none,                                 // 4
        '{valid: 1'b1, value: 32'h0000_001e},      // 5
        '{valid: 1'b1, value: 32'h0000_0036},      // 6
        '{valid: 1'b1, value: 32'h0000_0078},      // 7
        '{valid: 1'b1, value: 32'h0000_00b8},      // 8
        '{valid: 1'b1, value: 32'h0000_01b0},      // 9
        '{valid: 1'b1, value: 32'h0000_0360},      // 10
        '{valid: 1'b1, value: 32'h0000_0740},      // 11
        '{valid: 1'b1, value: 32'h0000_0ca0},      // 12
        '{valid: 1'b1, value: 32'h0000_1b00},      // 13
        '{valid: 1'b1, value: 32'h0000_3500},      // 14
        '{valid: 1'b1, value: 32'h0000_7400},      // 15
        '{valid: 1'b1, value: 32'h0000_b400},      // 16
        '{valid: 1'b1, value: 32'h0001_e000},      // 17
        '{valid: 1'b1, value: 32'h0003_9000},      // 18
        '{valid: 1'b1, value: 32'h0007_2000},      // 19
        '{valid: 1'b1, value: 32'h000c_a000},      // 20
        '{valid: 1'b1, value: 32'h001c_8000},      // 21
        '{valid: 1'b1, value: 32'h0027_0000},      // 22
        '{valid: 1'b1, value: 32'h006a_0000},      // 23
        '{valid: 1'b1, value: 32'h00d8_0000},      // 24
        '{valid: 1'b1, value: 32'h01e0_0000},      // 25
        '{valid: 1'b1, value: 32'h0388_0000},      // 26
        '{valid: 1'b1, value: 32'h0720_0000},      // 27
        '{valid: 1'b1, value: 32'h0ca0_0000},      // 28
        '{valid: 1'b1, value: 32'h1d00_0000},      // 29
        '{valid: 1'b1, value: 32'h3280_0000},      // 30
        '{valid: 1'b1, value: 32'h7800_0000}       // 31
    };

endpackage

`default_nettype wire
